// ==== source/msx_bus_pkg.sv ====
// CPU bus constants
package msx_bus_pkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------
	localparam int addr_w		= 16;		// Z80 address bus
	localparam int data_w		= 8;		// Z80 data bus
	localparam int sdram_addr_w	= 23;		// 8MB byte address

	// ----------------------------------------
	// I/O port map, low byte of the address
	// ----------------------------------------
	// PPI occupies A8h..ABh
	localparam logic [7:0] ppi_port	= 8'hA8;

	// PSG occupies A0h..A3h
	localparam logic [7:0] psg_port	= 8'hA0;

	// VDP occupies 98h..99h
	localparam logic [7:0] vdp_port	= 8'h98;

	// ----------------------------------------
	// Memory-mapped registers
	// ----------------------------------------
	// Expanded slot register, last byte of page 3
	localparam logic [addr_w-1:0] exp_reg_addr = 16'hFFFF;

	// Pull-ups on an undriven data bus
	localparam logic [data_w-1:0] idle_data = 8'hFF;

endpackage

// ==== source/msx_map_pkg.sv ====
// Slot and SDRAM segment map
package msx_map_pkg;

	// ----------------------------------------
	// Slot select byte
	// ----------------------------------------
	// Same byte for the primary register (A8h) and the
	// expanded registers (FFFFh). Two bits per 16KB page,
	// page 0 in bits 1:0, page 3 in bits 7:6
	typedef union packed {
		logic [7:0]			raw;	// As written by the CPU
		logic [3:0][1:0]	page;	// Slot number per page
	} slot_select_u;

	// ----------------------------------------
	// SDRAM segments
	// ----------------------------------------
	// SDRAM address = {segment, a[12:0]}, so one segment is 8KB
	localparam int seg_w = 10;

	// Mapper RAM in slot 3-0, 128KB window
	localparam logic [seg_w-1:0] seg_mapper	= 10'h200;

	// MegaROM cartridge images
	localparam logic [seg_w-1:0] seg_mega1	= 10'h100;	// Slot 1, 1MB
	localparam logic [seg_w-1:0] seg_mega2	= 10'h020;	// Slot 2, 512KB

	// Built-in ROMs of slot 0
	localparam logic [seg_w-1:0] seg_logo	= 10'h01C;	// 0-3, logo and ext BASIC
	localparam logic [seg_w-1:0] seg_music	= 10'h01A;	// 0-2, MSX-MUSIC
	localparam logic [seg_w-1:0] seg_iot	= 10'h018;	// 0-1, IoT BASIC
	localparam logic [seg_w-1:0] seg_main	= 10'h010;	// 0-0, main ROM

	// Built-in ROMs of slot 3
	localparam logic [seg_w-1:0] seg_sub	= 10'h014;	// 3-1, sub ROM and kanji BASIC
	localparam logic [seg_w-1:0] seg_nextor	= 10'h000;	// 3-2, Nextor banks

endpackage

// ==== source/clock_enable_gen.sv ====
// Clock enable generator
`timescale 1ns/1ps

module clock_enable_gen #(
	parameter int unsigned cpu_div_count = 12,	// clk42m cycles per CPU tick
	parameter int unsigned psg_div_count = 12	// clk42m cycles per PSG tick
) (
	input	logic	clk42m,
	input	logic	ff_reset_n,
	input	logic	cpu_freeze,			// Held by the SPI updater
	input	logic	sdram_init_busy,	// SDRAM still in power-up sequence
	output	logic	sys_enable,
	output	logic	cpu_enable,
	output	logic	psg_enable
);
	localparam int cpu_cnt_w = $clog2(cpu_div_count);
	localparam int psg_cnt_w = $clog2(psg_div_count);

	logic					ff_clock_div;	// Half-rate toggle
	logic	[cpu_cnt_w-1:0]	ff_cpu_cnt;
	logic	[psg_cnt_w-1:0]	ff_psg_cnt;
	logic					w_run;			// Enables allowed

	// ----------------------------------------
	// System enable, every second cycle
	// ----------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_clock_div <= 1'b0;
		end else begin
			ff_clock_div <= ~ff_clock_div;
		end
	end
	assign sys_enable = ff_clock_div;

	// ----------------------------------------
	// CPU and PSG dividers
	// ----------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n || cpu_freeze) begin
			ff_cpu_cnt <= '0;				// Restart cleanly after freeze
		end else if (ff_cpu_cnt == cpu_cnt_w'(cpu_div_count - 1)) begin
			ff_cpu_cnt <= '0;
		end else begin
			ff_cpu_cnt <= ff_cpu_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n || cpu_freeze) begin
			ff_psg_cnt <= '0;
		end else if (ff_psg_cnt == psg_cnt_w'(psg_div_count - 1)) begin
			ff_psg_cnt <= '0;
		end else begin
			ff_psg_cnt <= ff_psg_cnt + 1'b1;
		end
	end

	// No ticks while frozen or while SDRAM is not ready
	assign w_run		= !cpu_freeze && !sdram_init_busy;
	assign cpu_enable	= w_run && (ff_cpu_cnt == cpu_cnt_w'(cpu_div_count - 1));
	assign psg_enable	= w_run && (ff_psg_cnt == psg_cnt_w'(psg_div_count - 1));

endmodule

// ==== source/primary_slot_reg.sv ====
// Primary slot select register
`timescale 1ns/1ps

module primary_slot_reg (
	input	logic							clk42m,
	input	logic							ff_reset_n,
	input	logic	[msx_bus_pkg::addr_w-1:0]	a,
	input	logic	[msx_bus_pkg::data_w-1:0]	wdata,
	input	logic							iorq_n,
	input	logic							mreq_n,
	input	logic							rd_n,
	input	logic							wr_n,
	output	logic	[msx_bus_pkg::data_w-1:0]	q,
	output	logic							q_en,
	output	logic	[3:0]					sltsl		// One line per primary slot
);
	msx_map_pkg::slot_select_u	ff_slot;			// Port A8h contents
	logic						ff_wr_seen;
	logic						ff_rd_seen;
	logic						ff_q_en;
	logic	[msx_bus_pkg::data_w-1:0]	ff_q;
	logic						w_ppi_sel;
	logic						w_wr_strobe;
	logic						w_rd_strobe;
	logic	[1:0]				w_page_slot;

	// PPI decode, A8h..ABh
	assign w_ppi_sel	= ({a[7:2], 2'b00} == msx_bus_pkg::ppi_port);
	assign w_wr_strobe	= !iorq_n && !wr_n && w_ppi_sel;
	assign w_rd_strobe	= !iorq_n && !rd_n && w_ppi_sel;

	// ----------------------------------------
	// Register write, first edge only
	// ----------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_slot.raw	<= '0;				// All pages on slot 0 at boot
			ff_wr_seen	<= 1'b0;
		end else begin
			ff_wr_seen	<= w_wr_strobe;
			if (w_wr_strobe && !ff_wr_seen) begin
				ff_slot.raw <= wdata;
			end
		end
	end

	// Readback, one pulse per access
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rd_seen	<= 1'b0;
			ff_q_en		<= 1'b0;
		end else begin
			ff_rd_seen	<= w_rd_strobe;
			ff_q_en		<= w_rd_strobe && !ff_rd_seen;
		end
	end

	always_ff @(posedge clk42m) begin
		if (w_rd_strobe && !ff_rd_seen) begin
			ff_q <= ff_slot.raw;
		end
	end

	assign q	= ff_q;
	assign q_en	= ff_q_en;

	// ----------------------------------------
	// Slot select per page
	// ----------------------------------------
	assign w_page_slot = ff_slot.page[a[15:14]];	// Field of the current page

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			sltsl[i] = !mreq_n && (w_page_slot == 2'(i));
		end
	end

endmodule

// ==== source/expansion_slot_reg.sv ====
// Expanded slot select register
`timescale 1ns/1ps

module expansion_slot_reg (
	input	logic							clk42m,
	input	logic							ff_reset_n,
	input	logic							sltsl,		// Parent primary slot, mreq qualified
	input	logic	[msx_bus_pkg::addr_w-1:0]	a,
	input	logic	[msx_bus_pkg::data_w-1:0]	wdata,
	input	logic							rd_n,
	input	logic							wr_n,
	output	logic	[msx_bus_pkg::data_w-1:0]	q,
	output	logic							q_en,
	output	logic	[3:0]					sltsl_ext	// Secondary slots x-0..x-3
);
	msx_map_pkg::slot_select_u	ff_slot;
	logic						ff_wr_seen;
	logic						ff_rd_seen;
	logic						ff_q_en;
	logic	[msx_bus_pkg::data_w-1:0]	ff_q;
	logic						w_reg_hit;			// FFFFh inside this slot
	logic						w_wr_strobe;
	logic						w_rd_strobe;
	logic	[1:0]				w_page_slot;

	assign w_reg_hit	= sltsl && (a == msx_bus_pkg::exp_reg_addr);
	assign w_wr_strobe	= w_reg_hit && !wr_n;
	assign w_rd_strobe	= w_reg_hit && !rd_n;

	// ----------------------------------------
	// Register write and readback
	// ----------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_slot.raw	<= '0;
			ff_wr_seen	<= 1'b0;
			ff_rd_seen	<= 1'b0;
			ff_q_en		<= 1'b0;
		end else begin
			ff_wr_seen	<= w_wr_strobe;
			ff_rd_seen	<= w_rd_strobe;
			ff_q_en		<= w_rd_strobe && !ff_rd_seen;	// Single pulse
			if (w_wr_strobe && !ff_wr_seen) begin
				ff_slot.raw <= wdata;
			end
		end
	end

	// Software probes for expansion by reading back the complement
	always_ff @(posedge clk42m) begin
		if (w_rd_strobe && !ff_rd_seen) begin
			ff_q <= ~ff_slot.raw;
		end
	end

	assign q	= ff_q;
	assign q_en	= ff_q_en;

	// ----------------------------------------
	// Secondary slot decode
	// ----------------------------------------
	assign w_page_slot = ff_slot.page[a[15:14]];

	// The register itself hides whatever sits at FFFFh
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			sltsl_ext[i] = sltsl && !w_reg_hit && (w_page_slot == 2'(i));
		end
	end

endmodule

// ==== source/sdram_memory_map.sv ====
// Slot to SDRAM memory map
`timescale 1ns/1ps

module sdram_memory_map (
	input	logic	[msx_bus_pkg::addr_w-1:0]		a,
	input	logic	[msx_bus_pkg::data_w-1:0]		wdata,
	input	logic								rd_n,
	input	logic								wr_n,
	input	logic								mreq_n,
	input	logic								cpu_freeze,
	input	logic	[msx_bus_pkg::sdram_addr_w-1:0]	spi_address,
	input	logic	[msx_bus_pkg::data_w-1:0]		spi_wdata,
	input	logic								spi_mreq_n,
	input	logic								sltsl1,		// MegaROM 1
	input	logic								sltsl2,		// MegaROM 2
	input	logic	[3:0]						ext0,		// Slot 0-x
	input	logic	[3:0]						ext3,		// Slot 3-x
	output	logic	[msx_bus_pkg::sdram_addr_w-1:0]	sdram_address,
	output	logic	[msx_bus_pkg::data_w-1:0]		sdram_wdata,
	output	logic								sdram_mreq_n,
	output	logic								sdram_wr_n,
	output	logic								sdram_rd_n
);
	localparam int seg_w = msx_map_pkg::seg_w;

	logic	[seg_w-1:0]	w_seg;			// 8KB segment for the CPU access
	logic				w_rd_ok;		// Page is readable in this slot
	logic				w_mapper;		// Only RAM accepts writes
	logic				w_page0;
	logic				w_page1;
	logic				w_page2;

	assign w_page0 = (a[15:14] == 2'd0);
	assign w_page1 = (a[15:14] == 2'd1);
	assign w_page2 = (a[15:14] == 2'd2);

	// ----------------------------------------
	// Segment priority
	// ----------------------------------------
	always_comb begin
		w_seg		= '0;
		w_rd_ok		= 1'b0;
		w_mapper	= 1'b0;
		if (ext3[0]) begin								// Mapper RAM, all pages
			w_seg		= msx_map_pkg::seg_mapper + seg_w'(a[15:13]);
			w_rd_ok		= 1'b1;
			w_mapper	= 1'b1;
		end else if (sltsl1) begin						// MegaROM 1MB
			w_seg		= msx_map_pkg::seg_mega1 + seg_w'(a[15:13]);
			w_rd_ok		= 1'b1;
		end else if (sltsl2) begin						// MegaROM 512KB, fixed base
			w_seg		= msx_map_pkg::seg_mega2;
			w_rd_ok		= w_page1 || w_page2;
		end else if (ext0[3]) begin						// Logo and ext BASIC
			w_seg		= msx_map_pkg::seg_logo + seg_w'(a[14:13]);
			w_rd_ok		= w_page1 || w_page2;
		end else if (ext0[2]) begin
			w_seg		= msx_map_pkg::seg_music + seg_w'(a[13]);	// MSX-MUSIC
			w_rd_ok		= w_page1;
		end else if (ext0[1]) begin
			w_seg		= msx_map_pkg::seg_iot + seg_w'(a[13]);		// IoT BASIC
			w_rd_ok		= w_page1;
		end else if (ext3[1]) begin						// Sub ROM, kanji BASIC
			w_seg		= msx_map_pkg::seg_sub + seg_w'(a[14:13]);
			w_rd_ok		= w_page0 || w_page1;
		end else if (ext0[0]) begin						// Main ROM, 32KB
			w_seg		= msx_map_pkg::seg_main + seg_w'(a[14:13]);
			w_rd_ok		= w_page0 || w_page1;
		end else if (ext3[2]) begin						// Nextor banks 0-7
			w_seg		= msx_map_pkg::seg_nextor + seg_w'(a[15:13]);
			w_rd_ok		= w_page1 || w_page2;
		end else if (ext3[3]) begin
			// Slot 3-3 is empty, nothing answers
			w_seg		= '0;
			w_rd_ok		= 1'b0;
		end
	end

	// ----------------------------------------
	// Output mux, SPI updater wins under freeze
	// ----------------------------------------
	assign sdram_address	= cpu_freeze ? spi_address : {w_seg, a[12:0]};
	assign sdram_wdata		= cpu_freeze ? spi_wdata : wdata;
	assign sdram_mreq_n		= cpu_freeze ? spi_mreq_n : mreq_n;
	assign sdram_wr_n		= cpu_freeze ? spi_mreq_n :		// Updater only writes
							  w_mapper   ? wr_n : 1'b1;
	assign sdram_rd_n		= cpu_freeze ? 1'b1 :
							  w_rd_ok    ? rd_n : 1'b1;

endmodule

// ==== source/cpu_data_bus.sv ====
// CPU read data bus and I/O selects
`timescale 1ns/1ps

module cpu_data_bus (
	input	logic							clk42m,
	input	logic							ff_reset_n,
	input	logic	[7:0]					a,			// I/O port number
	input	logic							iorq_n,
	input	logic							rd_n,
	input	logic	[msx_bus_pkg::data_w-1:0]	sdram_q,
	input	logic							sdram_q_en,
	input	logic	[msx_bus_pkg::data_w-1:0]	exp0_q,
	input	logic							exp0_q_en,
	input	logic	[msx_bus_pkg::data_w-1:0]	exp3_q,
	input	logic							exp3_q_en,
	input	logic	[msx_bus_pkg::data_w-1:0]	ppi_q,
	input	logic							ppi_q_en,
	output	logic	[msx_bus_pkg::data_w-1:0]	rdata,
	output	logic							vdp_cs_n,
	output	logic							psg_cs_n
);
	logic	[msx_bus_pkg::data_w-1:0]	ff_rdata;

	// ----------------------------------------
	// Read data latch
	// ----------------------------------------
	// Sources pulse q_en once, the latch holds the byte until rd_n rises
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rdata <= msx_bus_pkg::idle_data;
		end else if (sdram_q_en) begin
			ff_rdata <= sdram_q;
		end else if (exp0_q_en) begin
			ff_rdata <= exp0_q;
		end else if (exp3_q_en) begin
			ff_rdata <= exp3_q;
		end else if (ppi_q_en) begin
			ff_rdata <= ppi_q;
		end else if (rd_n) begin
			ff_rdata <= msx_bus_pkg::idle_data;	// Bus released
		end
	end

	assign rdata = ff_rdata;

	// ----------------------------------------
	// I/O chip selects
	// ----------------------------------------
	// VDP at 98h..99h
	assign vdp_cs_n = !(!iorq_n && ({a[7:1], 1'b0} == msx_bus_pkg::vdp_port));

	// PSG at A0h..A3h
	assign psg_cs_n = !(!iorq_n && ({a[7:2], 2'b00} == msx_bus_pkg::psg_port));

endmodule

// ==== source/msx_bus_top.sv ====
// CPU bus glue top level
`timescale 1ns/1ps

module msx_bus_top #(
	parameter int unsigned cpu_div_count = 12,
	parameter int unsigned psg_div_count = 12
) (
	input	logic								clk42m,
	input	logic								ff_reset_n,
	// CPU bus
	input	logic	[msx_bus_pkg::addr_w-1:0]		a,
	input	logic	[msx_bus_pkg::data_w-1:0]		wdata,
	input	logic								mreq_n,
	input	logic								iorq_n,
	input	logic								rd_n,
	input	logic								wr_n,
	output	logic	[msx_bus_pkg::data_w-1:0]		rdata,
	// Control
	input	logic								cpu_freeze,
	input	logic								sdram_init_busy,
	output	logic								sys_enable,
	output	logic								cpu_enable,
	output	logic								psg_enable,
	output	logic								vdp_cs_n,
	output	logic								psg_cs_n,
	// SPI updater
	input	logic	[msx_bus_pkg::sdram_addr_w-1:0]	spi_address,
	input	logic	[msx_bus_pkg::data_w-1:0]		spi_wdata,
	input	logic								spi_mreq_n,
	// SDRAM request side
	input	logic	[msx_bus_pkg::data_w-1:0]		sdram_q,
	input	logic								sdram_q_en,
	output	logic	[msx_bus_pkg::sdram_addr_w-1:0]	sdram_address,
	output	logic	[msx_bus_pkg::data_w-1:0]		sdram_wdata,
	output	logic								sdram_mreq_n,
	output	logic								sdram_wr_n,
	output	logic								sdram_rd_n
);
	logic	[3:0]						sltsl;			// Primary slots
	logic	[3:0]						sltsl_ext0;		// Slot 0-x
	logic	[3:0]						sltsl_ext3;		// Slot 3-x
	logic	[msx_bus_pkg::data_w-1:0]	ppi_q;
	logic								ppi_q_en;
	logic	[msx_bus_pkg::data_w-1:0]	exp0_q;
	logic								exp0_q_en;
	logic	[msx_bus_pkg::data_w-1:0]	exp3_q;
	logic								exp3_q_en;

	// ----------------------------------------
	// Enables
	// ----------------------------------------
	clock_enable_gen #(
		.cpu_div_count	(cpu_div_count),
		.psg_div_count	(psg_div_count)
	) u_clock_enable (
		.clk42m				(clk42m),
		.ff_reset_n			(ff_reset_n),
		.cpu_freeze			(cpu_freeze),
		.sdram_init_busy	(sdram_init_busy),
		.sys_enable			(sys_enable),
		.cpu_enable			(cpu_enable),
		.psg_enable			(psg_enable)
	);

	// ----------------------------------------
	// Slot selects
	// ----------------------------------------
	primary_slot_reg u_primary_slot (
		.clk42m		(clk42m),
		.ff_reset_n	(ff_reset_n),
		.a			(a),
		.wdata		(wdata),
		.iorq_n		(iorq_n),
		.mreq_n		(mreq_n),
		.rd_n		(rd_n),
		.wr_n		(wr_n),
		.q			(ppi_q),
		.q_en		(ppi_q_en),
		.sltsl		(sltsl)
	);

	expansion_slot_reg exp0 (
		.clk42m		(clk42m),
		.ff_reset_n	(ff_reset_n),
		.sltsl		(sltsl[0]),
		.a			(a),
		.wdata		(wdata),
		.rd_n		(rd_n),
		.wr_n		(wr_n),
		.q			(exp0_q),
		.q_en		(exp0_q_en),
		.sltsl_ext	(sltsl_ext0)
	);

	expansion_slot_reg exp3 (
		.clk42m		(clk42m),
		.ff_reset_n	(ff_reset_n),
		.sltsl		(sltsl[3]),
		.a			(a),
		.wdata		(wdata),
		.rd_n		(rd_n),
		.wr_n		(wr_n),
		.q			(exp3_q),
		.q_en		(exp3_q_en),
		.sltsl_ext	(sltsl_ext3)
	);

	// ----------------------------------------
	// SDRAM map and read data
	// ----------------------------------------
	sdram_memory_map u_memory_map (
		.a				(a),
		.wdata			(wdata),
		.rd_n			(rd_n),
		.wr_n			(wr_n),
		.mreq_n			(mreq_n),
		.cpu_freeze		(cpu_freeze),
		.spi_address	(spi_address),
		.spi_wdata		(spi_wdata),
		.spi_mreq_n		(spi_mreq_n),
		.sltsl1			(sltsl[1]),
		.sltsl2			(sltsl[2]),
		.ext0			(sltsl_ext0),
		.ext3			(sltsl_ext3),
		.sdram_address	(sdram_address),
		.sdram_wdata	(sdram_wdata),
		.sdram_mreq_n	(sdram_mreq_n),
		.sdram_wr_n		(sdram_wr_n),
		.sdram_rd_n		(sdram_rd_n)
	);

	cpu_data_bus u_data_bus (
		.clk42m		(clk42m),
		.ff_reset_n	(ff_reset_n),
		.a			(a[7:0]),
		.iorq_n		(iorq_n),
		.rd_n		(rd_n),
		.sdram_q	(sdram_q),
		.sdram_q_en	(sdram_q_en),
		.exp0_q		(exp0_q),
		.exp0_q_en	(exp0_q_en),
		.exp3_q		(exp3_q),
		.exp3_q_en	(exp3_q_en),
		.ppi_q		(ppi_q),
		.ppi_q_en	(ppi_q_en),
		.rdata		(rdata),
		.vdp_cs_n	(vdp_cs_n),
		.psg_cs_n	(psg_cs_n)
	);

endmodule

// ==== sim/msx_bus_chk.sv ====
// Clock enable assertions
`timescale 1ns/1ps

module msx_bus_chk (
	input	logic	clk42m,
	input	logic	ff_reset_n,
	input	logic	cpu_freeze,
	input	logic	sdram_init_busy,
	input	logic	sys_enable,
	input	logic	cpu_enable,
	input	logic	psg_enable
);
	// ----------------------------------------
	// Gating by freeze and SDRAM init
	// ----------------------------------------
	a_cpu_gated: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		(cpu_freeze || sdram_init_busy) |-> !cpu_enable)
		else $error("cpu_enable high while frozen or SDRAM busy");

	// ----------------------------------------
	// Single-cycle pulses
	// ----------------------------------------
	a_sys_pulse: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		sys_enable |=> !sys_enable)
		else $error("sys_enable held longer than one cycle");
	a_cpu_pulse: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		cpu_enable |=> !cpu_enable)
		else $error("cpu_enable held longer than one cycle");
	a_psg_pulse: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		psg_enable |=> !psg_enable)
		else $error("psg_enable held longer than one cycle");

	// All quiet right after reset
	a_reset_low: assert property (@(posedge clk42m)
		!ff_reset_n |=> (!sys_enable && !cpu_enable && !psg_enable))
		else $error("enable pulse in the cycle after reset");

endmodule

bind clock_enable_gen msx_bus_chk chk0 (
	.clk42m				(clk42m),
	.ff_reset_n			(ff_reset_n),
	.cpu_freeze			(cpu_freeze),
	.sdram_init_busy	(sdram_init_busy),
	.sys_enable			(sys_enable),
	.cpu_enable			(cpu_enable),
	.psg_enable			(psg_enable)
);

// ==== sim/tb_msx_bus.sv ====
// CPU bus glue testbench
`timescale 1ns/1ps

module tb_msx_bus;
	logic			clk42m = 1'b0;
	logic			ff_reset_n;
	logic	[15:0]	a;
	logic	[7:0]	wdata;
	logic			mreq_n;
	logic			iorq_n;
	logic			rd_n;
	logic			wr_n;
	logic	[7:0]	rdata;
	logic			cpu_freeze;
	logic			sdram_init_busy;
	logic			sys_enable;
	logic			cpu_enable;
	logic			psg_enable;
	logic			vdp_cs_n;
	logic			psg_cs_n;
	logic	[22:0]	spi_address;
	logic	[7:0]	spi_wdata;
	logic			spi_mreq_n;
	logic	[7:0]	sdram_q;
	logic			sdram_q_en;
	logic	[22:0]	sdram_address;
	logic	[7:0]	sdram_wdata;
	logic			sdram_mreq_n;
	logic			sdram_wr_n;
	logic			sdram_rd_n;
	int				cycle_count = 0;	// Rising edges since time zero
	int				fail_count = 0;

	always #4 clk42m = ~clk42m;			// 125 MHz stand-in for 42.95 MHz
	always @(posedge clk42m) cycle_count <= cycle_count + 1;

	msx_bus_top #(
		.cpu_div_count	(12),
		.psg_div_count	(12)
	) dut0 (.*);

	// ----------------------------------------
	// Checking
	// ----------------------------------------
	task automatic check(input string test_name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			fail_count++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("STATUS: FAIL");
		$fatal(1, "Stopped on a timeout");
	endtask

	// ----------------------------------------
	// CPU bus cycles
	// ----------------------------------------
	task automatic start_cycle(input logic [15:0] addr, input logic [7:0] data,
			input bit is_io, input bit is_write);
		@(posedge clk42m);
		a		<= addr;
		wdata	<= data;
		mreq_n	<= is_io;
		iorq_n	<= !is_io;
		rd_n	<= is_write;
		wr_n	<= !is_write;
	endtask

	task automatic end_cycle();
		@(posedge clk42m);
		mreq_n	<= 1'b1;
		iorq_n	<= 1'b1;
		rd_n	<= 1'b1;
		wr_n	<= 1'b1;
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		start_cycle({8'h00, port}, data, 1'b1, 1'b1);
		@(posedge clk42m);				// Register loads here
		end_cycle();
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		start_cycle(addr, data, 1'b0, 1'b1);
		@(posedge clk42m);
		end_cycle();
	endtask

	// Strobe seen on the first edge, rdata loaded on the second
	task automatic io_read(input logic [7:0] port, output logic [7:0] data);
		start_cycle({8'h00, port}, 8'h00, 1'b1, 1'b0);
		repeat (2) @(posedge clk42m);
		@(negedge clk42m);
		data = rdata;
		end_cycle();
	endtask

	task automatic mem_read(input logic [15:0] addr, output logic [7:0] data);
		start_cycle(addr, 8'h00, 1'b0, 1'b0);
		repeat (2) @(posedge clk42m);
		@(negedge clk42m);
		data = rdata;
		end_cycle();
	endtask

	// ----------------------------------------
	// Enables
	// ----------------------------------------
	task automatic wait_enable(input bit use_sys, output int at_cycle);
		for (int i = 0; i < 40; i++) begin
			@(negedge clk42m);
			if (use_sys ? sys_enable : cpu_enable) begin
				at_cycle = cycle_count;
				return;
			end
		end
		report_timeout(use_sys ? "a sys_enable pulse" : "a cpu_enable pulse");
	endtask

	task automatic test_enables();
		int t0;
		int t1;
		wait_enable(1'b0, t0);
		check("enables psg with cpu", 1, psg_enable);	// Same count, same restart
		wait_enable(1'b0, t1);
		check("enables psg with cpu", 1, psg_enable);
		check("enables cpu period", 12, t1 - t0);
		wait_enable(1'b1, t0);
		wait_enable(1'b1, t1);
		check("enables sys period", 2, t1 - t0);
		@(posedge clk42m);
		cpu_freeze <= 1'b1;
		repeat (30) begin
			@(negedge clk42m);
			check("enables frozen", 0, cpu_enable);
			check("enables frozen psg", 0, psg_enable);
		end
		@(posedge clk42m);
		cpu_freeze		<= 1'b0;
		sdram_init_busy	<= 1'b1;
		repeat (30) begin
			@(negedge clk42m);
			check("enables sdram busy", 0, cpu_enable);
			check("enables sdram busy psg", 0, psg_enable);
		end
		@(posedge clk42m);
		sdram_init_busy <= 1'b0;
	endtask

	// ----------------------------------------
	// Slot registers and I/O selects
	// ----------------------------------------
	task automatic test_primary();
		logic [7:0] d;
		logic [7:0] r;
		d = 8'($urandom);
		io_write(8'hA8, d);
		io_read(8'hA8, r);
		check("primary readback", d, r);
		io_read(8'h00, r);				// Nothing answers at port 00h
		check("primary idle read", 8'hFF, r);
		start_cycle(16'h00A0, 8'h00, 1'b1, 1'b0);
		@(negedge clk42m);
		check("psg select", 0, psg_cs_n);
		check("psg select vdp", 1, vdp_cs_n);
		end_cycle();
		start_cycle(16'h0098, 8'h00, 1'b1, 1'b0);
		@(negedge clk42m);
		check("vdp select", 0, vdp_cs_n);
		check("vdp select psg", 1, psg_cs_n);
		end_cycle();
		@(negedge clk42m);
		check("selects idle", 2'b11, {vdp_cs_n, psg_cs_n});
	endtask

	task automatic test_expanded();
		logic [7:0] d;
		logic [7:0] r;
		logic [7:0] inv;
		io_write(8'hA8, 8'h00);			// Page 3 on slot 0
		d = 8'($urandom);
		inv = ~d;
		mem_write(16'hFFFF, d);
		mem_read(16'hFFFF, r);
		check("expanded slot 0", inv, r);
		io_write(8'hA8, 8'hC0);			// Page 3 on slot 3
		d = 8'($urandom);
		inv = ~d;
		mem_write(16'hFFFF, d);
		mem_read(16'hFFFF, r);
		check("expanded slot 3", inv, r);
	endtask

	// ----------------------------------------
	// Memory map reference
	// ----------------------------------------
	function automatic void map_model(input logic [1:0] slot, input logic [1:0] sub,
			input logic [15:0] addr, output logic [22:0] exp_addr,
			output logic rd_ok, output logic ram);
		logic [9:0] seg;
		logic [1:0] pg;
		pg = addr[15:14];
		seg = 10'h000;
		rd_ok = 1'b0;
		ram = 1'b0;
		if (slot == 2'd1) begin
			seg = 10'h100 + addr[15:13];	// MegaROM 1
			rd_ok = 1'b1;
		end else if (slot == 2'd2) begin
			seg = 10'h020;
			rd_ok = (pg == 2'd1) || (pg == 2'd2);
		end else begin
			case ({slot, sub})
				4'h0: begin
					seg = 10'h010 + addr[14:13];	// Main ROM
					rd_ok = (pg == 2'd0) || (pg == 2'd1);
				end
				4'h1: begin
					seg = 10'h018 + addr[13];
					rd_ok = (pg == 2'd1);
				end
				4'h2: begin
					seg = 10'h01A + addr[13];
					rd_ok = (pg == 2'd1);
				end
				4'h3: begin
					seg = 10'h01C + addr[14:13];	// Logo
					rd_ok = (pg == 2'd1) || (pg == 2'd2);
				end
				4'hC: begin
					seg = 10'h200 + addr[15:13];	// Mapper RAM
					rd_ok = 1'b1;
					ram = 1'b1;
				end
				4'hD: begin
					seg = 10'h014 + addr[14:13];
					rd_ok = (pg == 2'd0) || (pg == 2'd1);
				end
				4'hE: begin
					seg = 10'h000 + addr[15:13];	// Nextor
					rd_ok = (pg == 2'd1) || (pg == 2'd2);
				end
				default: begin
					seg = 10'h000;					// Slot 3-3 empty
				end
			endcase
		end
		exp_addr = {seg, addr[12:0]};
	endfunction

	task automatic map_case(input logic [1:0] slot, input logic [1:0] sub,
			input logic [1:0] page, input bit is_write);
		logic [15:0] addr;
		logic [22:0] exp_addr;
		logic [7:0] wd;
		logic rd_ok;
		logic ram;
		string name;
		io_write(8'hA8, {4{slot}});			// Every page on this slot
		mem_write(16'hFFFF, {4{sub}});		// Every page on this subslot
		addr = {page, 14'($urandom)};
		if (addr == 16'hFFFF) begin
			addr[0] = 1'b0;					// Keep clear of the register
		end
		wd = 8'($urandom);
		map_model(slot, sub, addr, exp_addr, rd_ok, ram);
		name = $sformatf("map %0d-%0d page %0d", slot, sub, page);
		start_cycle(addr, wd, 1'b0, is_write);
		@(negedge clk42m);
		check({name, " address"}, exp_addr, sdram_address);
		check({name, " rd_n"}, (!is_write && rd_ok) ? 1'b0 : 1'b1, sdram_rd_n);
		check({name, " wr_n"}, (is_write && ram) ? 1'b0 : 1'b1, sdram_wr_n);
		check({name, " mreq_n"}, 0, sdram_mreq_n);
		check({name, " wdata"}, wd, sdram_wdata);
		end_cycle();
	endtask

	task automatic test_memory_map();
		for (int n = 0; n < 2; n++) begin
			map_case(2'd3, 2'd0, 2'd2, 1'b1);	// Mapper write
			map_case(2'd3, 2'd0, 2'd1, 1'b0);
			map_case(2'd0, 2'd0, 2'd2, 1'b0);	// Main ROM page 2, no read
			map_case(2'd0, 2'd0, 2'd0, 1'b0);
			map_case(2'd2, 2'd0, 2'd1, 1'b0);
			map_case(2'd2, 2'd0, 2'd3, 1'b0);
			map_case(2'd1, 2'd0, 2'd3, 1'b0);
			map_case(2'd1, 2'd0, 2'd0, 1'b1);	// ROM ignores writes
			map_case(2'd0, 2'd3, 2'd1, 1'b0);
			map_case(2'd0, 2'd2, 2'd1, 1'b0);
			map_case(2'd0, 2'd1, 2'd1, 1'b0);
			map_case(2'd3, 2'd1, 2'd0, 1'b0);
			map_case(2'd3, 2'd2, 2'd2, 1'b0);
			map_case(2'd3, 2'd3, 2'd1, 1'b0);
		end
	endtask

	// ----------------------------------------
	// Freeze path and SDRAM read data
	// ----------------------------------------
	task automatic test_freeze_and_sdram();
		logic [22:0] sa;
		logic [7:0] sd;
		logic [7:0] d;
		sa = 23'($urandom);
		sd = 8'($urandom);
		@(posedge clk42m);
		cpu_freeze	<= 1'b1;
		spi_address	<= sa;
		spi_wdata	<= sd;
		spi_mreq_n	<= 1'b0;
		@(negedge clk42m);
		check("freeze address", sa, sdram_address);
		check("freeze wdata", sd, sdram_wdata);
		check("freeze strobes", 3'b001, {sdram_mreq_n, sdram_wr_n, sdram_rd_n});
		@(posedge clk42m);
		spi_mreq_n <= 1'b1;
		@(negedge clk42m);
		check("freeze idle", 3'b111, {sdram_mreq_n, sdram_wr_n, sdram_rd_n});
		@(posedge clk42m);
		cpu_freeze <= 1'b0;
		io_write(8'hA8, 8'h00);
		d = 8'($urandom);
		start_cycle(16'h0123, 8'h00, 1'b0, 1'b0);
		@(posedge clk42m);
		sdram_q		<= d;				// Controller answers one cycle later
		sdram_q_en	<= 1'b1;
		@(posedge clk42m);
		sdram_q_en	<= 1'b0;
		@(negedge clk42m);
		check("sdram read data", d, rdata);
		end_cycle();
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		void'($urandom(55212));
		ff_reset_n		= 1'b0;
		a				= '0;
		wdata			= '0;
		mreq_n			= 1'b1;
		iorq_n			= 1'b1;
		rd_n			= 1'b1;
		wr_n			= 1'b1;
		cpu_freeze		= 1'b0;
		sdram_init_busy	= 1'b0;
		spi_address		= '0;
		spi_wdata		= '0;
		spi_mreq_n		= 1'b1;
		sdram_q			= '0;
		sdram_q_en		= 1'b0;
		repeat (2) @(posedge clk42m);
		ff_reset_n <= 1'b1;
		test_enables();
		test_primary();
		test_expanded();
		test_memory_map();
		test_freeze_and_sdram();
		if (fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
source/msx_bus_pkg.sv
source/msx_map_pkg.sv
source/clock_enable_gen.sv
source/primary_slot_reg.sv
source/expansion_slot_reg.sv
source/sdram_memory_map.sv
source/cpu_data_bus.sv
source/msx_bus_top.sv
sim/msx_bus_chk.sv
sim/tb_msx_bus.sv
